// File: logic/cps2_dec_pkg.sv
/*
 * CPS2 opcode decryption, shared definitions.
 * Word, address, key and Feistel half types, stream constants
 * and the keyed round function used by the cipher lane.
 */
package cps2_dec_pkg;

    typedef logic [15:0] word_t;      // Fetched data word, cipher or plain
    typedef logic [22:0] addr_t;      // 68000 word address, byte bits 23..1
    typedef logic [63:0] key_t;       // Four 16-bit subkeys
    typedef logic [15:0] limit_t;     // Compared with byte address 23..8
    typedef logic [7:0]  cfg_byte_t;  // One configuration byte
    typedef logic [7:0]  half_t;      // One Feistel half of a word

    localparam int CFG_BYTES  = 20;   // Configuration stream length
    localparam int MAX_ROUNDS = 4;    // Subkeys held by key_t

    // Substitute round function; stands in for the CPS2 S-box network
    function automatic half_t cipher_f(
        input half_t r,
        input word_t subkey,
        input addr_t addr
    );
        half_t t;
        t = r ^ subkey[7:0];                  // Mix with low subkey byte
        t = {t[6:0], t[7]} + subkey[15:8];    // Rotate, add high byte, mod 256
        return t ^ addr[7:0];                 // Byte address bits 8..1
    endfunction

endpackage

// File: logic/cps2_fetch_if.sv
/*
 * Fetch request bundle.
 * One beat of a CPU fetch: valid, opcode flag, address and data word.
 */
interface cps2_fetch_if
    import cps2_dec_pkg::*;
();

    logic  valid;   // Beat present
    logic  opcode;  // Opcode fetch, data fetch when low
    addr_t addr;    // Word address
    word_t data;    // Word as read from ROM

    // Side that presents the beat
    modport source (
        output valid, opcode, addr, data
    );

    // Lanes that consume the beat
    modport sink (
        input valid, opcode, addr, data
    );

endinterface

// File: logic/cps2_keyload.sv
/*
 * Configuration key loader.
 * Shifts in the 20-byte stream on write-strobe rising edges and
 * rearranges it into the cipher key and the upper address limit.
 */
module cps2_keyload
    import cps2_dec_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  cfg_byte_t cfg_din,
    input  logic      cfg_we,
    output key_t      key,
    output limit_t    limit,
    output logic      key_valid
);

    localparam int RAW_W = 8 * CFG_BYTES;

    logic             cfg_we_q;    // Registered strobe
    logic             shift_en;    // Strobe rising edge
    logic [RAW_W-1:0] raw;         // Byte k at raw[8k +: 8]
    logic [4:0]       cfg_cnt;     // Bytes seen, saturating
    word_t            limit_pair;  // Bytes 19 and 18

    assign shift_en = cfg_we && !cfg_we_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg_we_q <= 1'b0;
            raw      <= '0;
            cfg_cnt  <= '0;
        end else begin
            cfg_we_q <= cfg_we;
            if (shift_en) begin
                raw <= {cfg_din, raw[RAW_W-1:8]};  // Newest byte at the top
                if (cfg_cnt != 5'(CFG_BYTES)) begin
                    cfg_cnt <= cfg_cnt + 5'd1;     // Stops at full stream
                end
            end
        end
    end

    // Stays high once the stream has been seen in full
    assign key_valid = (cfg_cnt == 5'(CFG_BYTES));

    // Subkey i from bytes 2i+1 and 2i, rotated left by two
    for (genvar i = 0; i < MAX_ROUNDS; i++) begin : g_subkey
        word_t pair;
        assign pair           = raw[16*i +: 16];
        assign key[16*i +: 16] = {pair[13:0], pair[15:14]};
    end

    // Bytes 8 to 17 reserved, not used here

    assign limit_pair = raw[RAW_W-1 -: 16];                 // Bytes 19 high, 18 low
    assign limit      = {limit_pair[13:0], limit_pair[15:14]};

endmodule

// File: logic/cps2_cipher_lane.sv
/*
 * Cipher lane.
 * Feistel decryption of the fetched word, one round per pipeline
 * stage, subkeys applied from the highest in use down to zero.
 */
module cps2_cipher_lane
    import cps2_dec_pkg::*;
#(
    parameter int ROUNDS = 4
) (
    input  logic              clk,
    input  logic              rst,
    cps2_fetch_if.sink        req,
    input  key_t              key,
    input  logic              advance,
    output word_t             plain
);

    word_t stage_w [ROUNDS];  // Word entering round i
    addr_t stage_a [ROUNDS];  // Address riding with it
    word_t res     [ROUNDS];  // Word after round i

    // Round i undoes encryption round ROUNDS-1-i
    for (genvar i = 0; i < ROUNDS; i++) begin : g_round
        localparam int K = ROUNDS - 1 - i;
        word_t sk;
        half_t left;
        half_t right;

        assign sk    = key[16*K +: 16];
        assign left  = stage_w[i][15:8];
        assign right = stage_w[i][7:0];
        // New left is old right, new right is left mixed with f(right)
        assign res[i] = {right, left ^ cipher_f(right, sk, stage_a[i])};
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ROUNDS; i++) begin
                stage_w[i] <= '0;
                stage_a[i] <= '0;
            end
        end else if (advance) begin
            stage_w[0] <= req.data;            // Ciphertext enters
            stage_a[0] <= req.addr;
            for (int i = 1; i < ROUNDS; i++) begin
                stage_w[i] <= res[i-1];        // One round per stage
                stage_a[i] <= stage_a[i-1];
            end
        end
    end

    // Last round feeds the merge register directly
    assign plain = res[ROUNDS-1];

endmodule

// File: logic/cps2_range_lane.sv
/*
 * Range lane.
 * Decides per fetch whether it is decrypted and delays the raw word
 * and the stage valid to match the cipher lane depth.
 */
module cps2_range_lane
    import cps2_dec_pkg::*;
#(
    parameter int ROUNDS = 4
) (
    input  logic       clk,
    input  logic       rst,
    cps2_fetch_if.sink req,
    input  limit_t     limit,
    input  logic       key_valid,
    input  logic       advance,
    output word_t      raw,
    output logic       decrypt,
    output logic       last_valid
);

    logic  dec_in;           // Decision at entry
    logic  vld  [ROUNDS];    // Stage valids
    logic  flag [ROUNDS];    // Decrypt flag per stage
    word_t raw_w [ROUNDS];   // Untouched word

    // Opcode, key loaded, byte address 23..8 within limit
    assign dec_in = req.opcode && key_valid && (req.addr[22:7] <= limit);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ROUNDS; i++) begin
                vld[i]  <= 1'b0;
                flag[i] <= 1'b0;
            end
        end else if (advance) begin
            vld[0]  <= req.valid;
            flag[0] <= dec_in;
            for (int i = 1; i < ROUNDS; i++) begin
                vld[i]  <= vld[i-1];
                flag[i] <= flag[i-1];
            end
        end
    end

    // Payload delay line, no reset
    always_ff @(posedge clk) begin
        if (advance) begin
            raw_w[0] <= req.data;
            for (int i = 1; i < ROUNDS; i++) begin
                raw_w[i] <= raw_w[i-1];
            end
        end
    end

    assign raw        = raw_w[ROUNDS-1];
    assign decrypt    = flag[ROUNDS-1];
    assign last_valid = vld[ROUNDS-1];

endmodule

// File: logic/cps2_fetch_merge.sv
/*
 * Fetch merge.
 * Output register and stall control; picks the decrypted or the raw
 * word and drives the pipeline-wide advance.
 */
module cps2_fetch_merge
    import cps2_dec_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  word_t plain,
    input  word_t raw,
    input  logic  decrypt,
    input  logic  last_valid,
    input  logic  out_ready,
    output logic  advance,
    output logic  out_valid,
    output word_t out_data,
    output logic  out_decrypted
);

    // Move when the output slot is empty or being drained
    assign advance = !out_valid || out_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid     <= 1'b0;
            out_decrypted <= 1'b0;
        end else if (advance) begin
            out_valid     <= last_valid;
            out_decrypted <= decrypt;
        end
    end

    // Word select, held while stalled
    always_ff @(posedge clk) begin
        if (advance) begin
            out_data <= decrypt ? plain : raw;
        end
    end

endmodule

// File: logic/cps2_dec_top.sv
/*
 * CPS2 opcode decryption top level.
 * Key loader, cipher and range lanes side by side, and the merge stage.
 */
module cps2_dec_top
    import cps2_dec_pkg::*;
#(
    parameter int ROUNDS = 4  // 1 to MAX_ROUNDS
) (
    input  logic      clk,
    input  logic      rst,
    input  cfg_byte_t cfg_din,
    input  logic      cfg_we,
    input  logic      in_valid,
    output logic      in_ready,
    input  logic      in_opcode,
    input  addr_t     in_addr,
    input  word_t     in_data,
    output logic      out_valid,
    input  logic      out_ready,
    output word_t     out_data,
    output logic      out_decrypted,
    output logic      key_valid
);

    key_t   key;         // Loaded cipher key
    limit_t limit;       // Upper decrypt limit
    logic   advance;     // Pipeline step
    word_t  plain;       // Cipher lane result
    word_t  raw;         // Delayed original word
    logic   decrypt;     // Range lane decision
    logic   last_valid;  // Beat in last stage

    cps2_fetch_if req_if ();

    assign req_if.valid  = in_valid;
    assign req_if.opcode = in_opcode;
    assign req_if.addr   = in_addr;
    assign req_if.data   = in_data;
    assign in_ready      = advance;  // Accept whenever the pipe moves

    cps2_keyload u_keyload (
        .clk       (clk),
        .rst       (rst),
        .cfg_din   (cfg_din),
        .cfg_we    (cfg_we),
        .key       (key),
        .limit     (limit),
        .key_valid (key_valid)
    );

    cps2_cipher_lane #(.ROUNDS(ROUNDS)) u_cipher (
        .clk     (clk),
        .rst     (rst),
        .req     (req_if.sink),
        .key     (key),
        .advance (advance),
        .plain   (plain)
    );

    cps2_range_lane #(.ROUNDS(ROUNDS)) u_range (
        .clk        (clk),
        .rst        (rst),
        .req        (req_if.sink),
        .limit      (limit),
        .key_valid  (key_valid),
        .advance    (advance),
        .raw        (raw),
        .decrypt    (decrypt),
        .last_valid (last_valid)
    );

    cps2_fetch_merge u_merge (
        .clk           (clk),
        .rst           (rst),
        .plain         (plain),
        .raw           (raw),
        .decrypt       (decrypt),
        .last_valid    (last_valid),
        .out_ready     (out_ready),
        .advance       (advance),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_decrypted (out_decrypted)
    );

endmodule

// File: verification/cps2_dec_props.sv
/*
 * Bound checks for the decryption top level.
 * Output hold under back-pressure, reset state and the ready rule.
 */
module cps2_dec_props
    import cps2_dec_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  in_ready,
    input logic  out_valid,
    input logic  out_ready,
    input word_t out_data,
    input logic  key_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;  // Failed assertion count

    // Stalled beat keeps its word and stays valid
    a_stall_hold: assert property (
        @(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
    ) else begin
        fail_count++;
        $error("output beat changed while stalled");
    end

    // Nothing valid while reset is held
    a_reset_low: assert property (
        @(posedge clk) rst |-> (!out_valid && !key_valid)
    ) else begin
        fail_count++;
        $error("valid flag high during reset");
    end

    // Pipe accepts unless the output slot is full and blocked
    a_ready_rule: assert property (
        @(posedge clk) disable iff (rst)
        in_ready == !(out_valid && !out_ready)
    ) else begin
        fail_count++;
        $error("in_ready does not follow the output slot state");
    end

endmodule

bind cps2_dec_top cps2_dec_props u_props (
    .clk       (clk),
    .rst       (rst),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .key_valid (key_valid)
);

// File: verification/cps2_dec_tb.sv
/*
 * Testbench for the CPS2 opcode decryption path.
 * Loads a generated key, runs a fetch table through the DUT with and
 * without back-pressure and checks every response against a model.
 */
module cps2_dec_tb
    import cps2_dec_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ROUNDS      = 4;
    localparam int NUM_ROWS    = 16;
    localparam int PRE_ROWS    = 4;                   // Rows sent before the key
    localparam int TIMEOUT     = 4 * NUM_ROWS + 200;  // Cycle limit
    localparam int HALF_PERIOD = 50;
    localparam int DRIVE_DELAY = 5;                   // Input skew after the edge

    typedef struct packed {
        logic  opcode;
        addr_t addr;
        word_t cipher;    // As held in ROM, sent to the DUT
        word_t exp_data;  // Expected out_data
        logic  exp_dec;   // Expected out_decrypted
    } row_t;

    typedef struct packed {
        word_t       data;
        logic        dec;
        logic [31:0] cycle;  // Acceptance cycle
    } resp_t;

    logic      clk;
    logic      rst;
    cfg_byte_t cfg_din;
    logic      cfg_we;
    logic      in_valid;
    logic      in_ready;
    logic      in_opcode;
    addr_t     in_addr;
    word_t     in_data;
    logic      out_valid;
    logic      out_ready;
    word_t     out_data;
    logic      out_decrypted;
    logic      key_valid;

    logic [15:0] lfsr_state;
    cfg_byte_t   cfg_bytes [CFG_BYTES];  // Stream, byte 0 sent first
    key_t        mdl_key;
    limit_t      mdl_limit;
    row_t        rows [NUM_ROWS];
    resp_t       exp_q [$];              // Accepted, not yet answered
    resp_t       acc_e;
    resp_t       got_e;
    word_t       cur_data;               // Expectation for the offered beat
    logic        cur_dec;
    logic        stall_mode;
    logic        stall_now;
    logic        lat_check;
    int          cycle;
    int          checks;
    int          errors;
    int          err_mark;
    int          tests;
    int          bad_tests;

    cps2_dec_top #(.ROUNDS(ROUNDS)) u_dut (
        .clk           (clk),
        .rst           (rst),
        .cfg_din       (cfg_din),
        .cfg_we        (cfg_we),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_opcode     (in_opcode),
        .in_addr       (in_addr),
        .in_data       (in_data),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_data      (out_data),
        .out_decrypted (out_decrypted),
        .key_valid     (key_valid)
    );

    always #HALF_PERIOD clk = ~clk;  // 100 ns period

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // Taps 16,14,13,11
    endfunction

    // Collects n bits, one LFSR step each
    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic word_t rotl2(input word_t w);
        return {w[13:0], w[15:14]};
    endfunction

    function automatic half_t round_f(input half_t r, input word_t sk, input addr_t a);
        half_t t;
        t = r ^ sk[7:0];
        t = ((t << 1) | (t >> 7)) + sk[15:8];  // Rotate by one, add mod 256
        return t ^ a[7:0];
    endfunction

    // Forward Feistel, subkey 0 first
    function automatic word_t encrypt(input word_t p, input key_t k, input addr_t a);
        word_t w;
        w = p;
        for (int i = 0; i < ROUNDS; i++) begin
            w = {w[7:0] ^ round_f(w[15:8], k[16*i +: 16], a), w[15:8]};
        end
        return w;
    endfunction

    task automatic note_failure(input string msg);
        errors++;
        $display("error: %s", msg);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_key(input string name, input key_t got, input key_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_limit(input string name, input limit_t got, input limit_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors != err_mark) begin
            bad_tests++;
        end
        $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
        err_mark = errors;
    endtask

    // Random subkey bytes, limit bytes fixed so both ranges get hit
    task automatic make_config();
        for (int i = 0; i < CFG_BYTES - 2; i++) begin
            cfg_bytes[i] = take_bits(8);
        end
        cfg_bytes[18] = 8'h80;
        cfg_bytes[19] = 8'h0C;                            // Limit 16'h3200
        for (int i = 0; i < MAX_ROUNDS; i++) begin
            mdl_key[16*i +: 16] = rotl2({cfg_bytes[2*i+1], cfg_bytes[2*i]});
        end
        mdl_limit = rotl2({cfg_bytes[19], cfg_bytes[18]});
    endtask

    task automatic set_row(input int idx, input logic op, input addr_t a, input word_t p);
        rows[idx].opcode   = op;
        rows[idx].addr     = a;
        rows[idx].cipher   = encrypt(p, mdl_key, a);
        rows[idx].exp_dec  = op && (a[22:7] <= mdl_limit);  // Byte address 23..8
        rows[idx].exp_data = rows[idx].exp_dec ? p : rows[idx].cipher;
    endtask

    task automatic load_table();
        set_row(0,  1'b1, 23'h000000, 16'h4E71);
        set_row(1,  1'b1, 23'h000001, 16'h4EF9);
        set_row(2,  1'b0, 23'h000002, 16'h1234);  // Data fetch
        set_row(3,  1'b1, 23'h0012A4, 16'h303C);
        set_row(4,  1'b1, 23'h19007F, 16'h6000);  // Last word under the limit
        set_row(5,  1'b1, 23'h190080, 16'h4E75);  // First word above it
        set_row(6,  1'b0, 23'h0A5A5A, 16'hBEEF);
        set_row(7,  1'b1, 23'h7FFFFF, 16'hDEAD);
        set_row(8,  1'b1, 23'h123456, 16'h2F00);
        set_row(9,  1'b1, 23'h0000FF, 16'hFFFF);
        set_row(10, 1'b1, 23'h000080, 16'h0000);
        set_row(11, 1'b0, 23'h19007F, 16'h5555);
        set_row(12, 1'b1, 23'h3FFF00, 16'hA5A5);
        set_row(13, 1'b1, 23'h08F0F0, 16'h41F9);
        set_row(14, 1'b1, 23'h190000, 16'h7001);
        set_row(15, 1'b1, 23'h055AA5, 16'hC0DE);
    endtask

    // One strobe pulse, two cycles per byte
    task automatic send_cfg_byte(input cfg_byte_t b);
        @(posedge clk);
        #DRIVE_DELAY;
        cfg_din = b;
        cfg_we  = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        cfg_we  = 1'b0;
    endtask

    // Offers one row and holds it until accepted
    task automatic send_row(input int idx, input logic keyed, input logic expect_now);
        int waits;
        waits     = 0;
        in_valid  = 1'b1;
        in_opcode = rows[idx].opcode;
        in_addr   = rows[idx].addr;
        in_data   = rows[idx].cipher;
        cur_data  = keyed ? rows[idx].exp_data : rows[idx].cipher;
        cur_dec   = keyed ? rows[idx].exp_dec : 1'b0;  // No key, no decrypt
        @(posedge clk);
        while (!in_ready) begin
            waits++;
            @(posedge clk);
        end
        #DRIVE_DELAY;
        if (expect_now && waits != 0) begin
            note_failure($sformatf("row %0d waited %0d cycles for in_ready", idx, waits));
        end
    endtask

    task automatic run_rows(input int first, input int count, input logic keyed,
                            input logic expect_now);
        for (int i = first; i < first + count; i++) begin
            send_row(i, keyed, expect_now);
        end
        in_valid = 1'b0;
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
        end while (exp_q.size() != 0);  // All responses back
    endtask

    // Back-pressure source, random only in the stall test
    always @(posedge clk) begin
        stall_now = stall_mode;
        #DRIVE_DELAY;
        if (stall_now) begin
            out_ready = (take_bits(1) != 8'd0);
        end else begin
            out_ready = 1'b1;
        end
    end

    // Scoreboard, cycle count and run limit
    always @(posedge clk) begin
        if (!rst) begin
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    note_failure("response arrived with no request outstanding");
                end else begin
                    got_e = exp_q.pop_front();
                    check_word("out_data", out_data, got_e.data);
                    check_flag("out_decrypted", out_decrypted, got_e.dec);
                    // Output fills ROUNDS edges after acceptance, drains on the next
                    if (lat_check && (cycle - int'(got_e.cycle)) != ROUNDS + 1) begin
                        note_failure($sformatf("response took %0d cycles, expected %0d",
                                               cycle - int'(got_e.cycle), ROUNDS + 1));
                    end
                end
            end
            if (in_valid && in_ready) begin
                acc_e.data  = cur_data;
                acc_e.dec   = cur_dec;
                acc_e.cycle = cycle;
                exp_q.push_back(acc_e);
            end
        end
        cycle++;
        if (cycle >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b0;
        cfg_din    = '0;
        cfg_we     = 1'b0;
        in_valid   = 1'b0;
        in_opcode  = 1'b0;
        in_addr    = '0;
        in_data    = '0;
        out_ready  = 1'b1;
        cur_data   = '0;
        cur_dec    = 1'b0;
        stall_mode = 1'b0;
        lat_check  = 1'b0;
        lfsr_state = 16'd10;
        make_config();
        load_table();
        #1 rst = 1'b1;                    // Clean edge for the async reset

        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("key_valid", key_valid, 1'b0);
        check_flag("in_ready", in_ready, 1'b1);
        rst = 1'b0;
        finish_test("reset state");

        lat_check = 1'b1;
        run_rows(0, PRE_ROWS, 1'b0, 1'b1);
        finish_test("fetches before key load");

        for (int i = 0; i < CFG_BYTES - 1; i++) begin
            send_cfg_byte(cfg_bytes[i]);
        end
        check_flag("key_valid", key_valid, 1'b0);  // 19 bytes, not yet
        send_cfg_byte(cfg_bytes[CFG_BYTES-1]);
        check_flag("key_valid", key_valid, 1'b1);
        check_key("key", u_dut.key, mdl_key);
        check_limit("limit", u_dut.limit, mdl_limit);
        finish_test("key load");

        run_rows(0, NUM_ROWS, 1'b1, 1'b1);
        finish_test("back-to-back table");

        lat_check  = 1'b0;
        stall_mode = 1'b1;
        run_rows(0, NUM_ROWS, 1'b1, 1'b0);
        stall_mode = 1'b0;
        finish_test("table under random stalls");

        if (u_dut.u_props.fail_count != 0) begin
            note_failure($sformatf("%0d bound assertions failed", u_dut.u_props.fail_count));
        end
        finish_test("bound assertions");

        $display("tests %0d, failing tests %0d, checks %0d, errors %0d",
                 tests, bad_tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: cps2_dec.f
logic/cps2_dec_pkg.sv
logic/cps2_fetch_if.sv
logic/cps2_keyload.sv
logic/cps2_cipher_lane.sv
logic/cps2_range_lane.sv
logic/cps2_fetch_merge.sv
logic/cps2_dec_top.sv
verification/cps2_dec_props.sv
verification/cps2_dec_tb.sv

// File: Bender.yml
package:
  name: cps2_dec

sources:
  - logic/cps2_dec_pkg.sv
  - logic/cps2_fetch_if.sv
  - logic/cps2_keyload.sv
  - logic/cps2_cipher_lane.sv
  - logic/cps2_range_lane.sv
  - logic/cps2_fetch_merge.sv
  - logic/cps2_dec_top.sv
  - target: test
    files:
      - verification/cps2_dec_props.sv
      - verification/cps2_dec_tb.sv
